// File: sdram_cmd_sched.f
+incdir+design
design/sdram_pkg.sv
design/req_if.sv
design/page_if.sv
design/req_latch.sv
design/page_tracker.sv
design/cmd_sequencer.sv
design/addr_gen.sv
design/sdram_cmd_sched.sv
verif/sdram_cmd_sched_props.sv
verif/tb_sdram_cmd_sched.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -f sdram_cmd_sched.f \
  --top-module tb_sdram_cmd_sched -o sim_tb || exit 1
out=$(./obj_dir/sim_tb 2>&1)
echo "$out"
echo "$out" | grep -q "TEST PASS" && exit 0 || exit 1

// File: verif/tb_sdram_cmd_sched.sv
`timescale 1ns/1ps
`include "sdram_macros.svh"

module tb_sdram_cmd_sched import sdram_pkg::*; ();
  typedef struct packed {
    logic [2:0] cmd;
    logic chk_addr;
    logic chk_bank;
    logic [`SDRAM_ROW_W-1:0] addr;
    logic [`SDRAM_BANK_W-1:0] bank;
    logic rg;
    logic bg;
  } obs_t;
  typedef struct {
    int kind;  // 0 rand, 1 bulk, 2 both, 3 refresh
    logic we;
    logic [`SDRAM_ADDR_W-1:0] addr;  // Bulk address in a "both" entry
    logic we2;
    logic [`SDRAM_ADDR_W-1:0] addr2;  // Random address in a "both" entry
  } entry_t;

  localparam int N_ENTRY = 7;
  localparam int CYCLE_LIMIT = N_ENTRY * 64;

  logic INPUT_CLK, RST, refresh_strobe;
  logic [`SDRAM_ADDR_W-1:0] rand_addr, bulk_addr;
  logic rand_we, rand_req, bulk_we, bulk_req;
  logic rand_grant, bulk_grant;
  sdram_cmd_e cmd;
  logic [`SDRAM_ROW_W-1:0] sdram_addr;
  logic [`SDRAM_BANK_W-1:0] bank;

  entry_t tbl [N_ENTRY];
  obs_t exp_q [$];
  obs_t act_q [$];
  int cycle_cnt = 0;
  logic open_valid = 1'b0;
  sdram_page_t open_page;

  sdram_cmd_sched u_sdram_cmd_sched (.*);

  initial
  begin
    INPUT_CLK = 1'b0;
    forever #4 INPUT_CLK = ~INPUT_CLK;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      abort_run($sformatf("[FAIL] %s expected %0h actual %0h", name, exp, act));
    end
  endtask

  function automatic logic [`SDRAM_ADDR_W-1:0] mk_addr(input int row, input int bnk);
    return {14'(row), 3'(bnk), 9'($urandom % 512)};
  endfunction

  task automatic expect_cmd(input sdram_cmd_e c, input logic ca, input logic cb,
                            input int a, input int b, input logic rg, input logic bg);
    exp_q.push_back('{c, ca, cb, 14'(a), 3'(b), rg, bg});
  endtask

  // Reference model of the open page ----------------
  task automatic model_access(input logic [`SDRAM_ADDR_W-1:0] a, input logic we,
                              input logic is_bulk);
    sdram_page_t pg;
    pg = a[`SDRAM_ADDR_W-1 -: `SDRAM_PAGE_W];
    if (open_valid && open_page != pg)
      expect_cmd(PRCH, 1'b1, 1'b0, 'h400, 0, 1'b0, 1'b0);
    if (!open_valid || open_page != pg)
      expect_cmd(ACTV, 1'b1, 1'b1, pg.row, pg.bank, 1'b0, 1'b0);
    expect_cmd(we ? WRTE : READ, 1'b1, 1'b1, {a[8:0], 1'b0}, pg.bank, !is_bulk, is_bulk);
    open_valid = 1'b1;
    open_page = pg;
  endtask

  task automatic step();
    @(negedge INPUT_CLK);
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT)
      abort_run("Timeout: the scheduler stopped issuing commands");
    else if (cmd != NOOP)
      act_q.push_back('{cmd, 1'b0, 1'b0, sdram_addr, bank, rand_grant, bulk_grant});
  endtask

  task automatic compare_entry(input int i);
    obs_t e, a;
    string tn;
    tn = $sformatf("entry %0d", i);
    check_value({tn, " command count"}, exp_q.size(), act_q.size());
    while (exp_q.size() > 0)
    begin
      e = exp_q.pop_front();
      a = act_q.pop_front();
      check_value({tn, " cmd"}, e.cmd, a.cmd);
      if (e.chk_addr)
        check_value({tn, " sdram_addr"}, e.addr, a.addr);
      if (e.chk_bank)
        check_value({tn, " bank"}, e.bank, a.bank);
      check_value({tn, " rand_grant"}, e.rg, a.rg);
      check_value({tn, " bulk_grant"}, e.bg, a.bg);
    end
  endtask

  task automatic apply_entry(input int i);
    entry_t t;
    t = tbl[i];
    case (t.kind)
      3:
      begin
        if (open_valid)
          expect_cmd(PRCH, 1'b1, 1'b0, 'h400, 0, 1'b0, 1'b0);
        expect_cmd(ARSR, 1'b0, 1'b0, 0, 0, 1'b0, 1'b0);
        open_valid = 1'b0;
        refresh_strobe = ~refresh_strobe;
        do step(); while (cmd != ARSR);
      end
      2:
      begin
        model_access(t.addr, t.we, 1'b1);  // Bulk goes first
        model_access(t.addr2, t.we2, 1'b0);
        bulk_addr = t.addr;
        bulk_we = t.we;
        rand_addr = t.addr2;
        rand_we = t.we2;
        bulk_req = 1'b1;
        rand_req = 1'b1;
        while (bulk_req || rand_req)
        begin
          step();
          if (bulk_grant)
            bulk_req = 1'b0;
          if (rand_grant)
            rand_req = 1'b0;
        end
      end
      default:
      begin
        model_access(t.addr, t.we, t.kind == 1);
        if (t.kind == 1)
        begin
          bulk_addr = t.addr;
          bulk_we = t.we;
          bulk_req = 1'b1;
          do step(); while (!bulk_grant);
          bulk_req = 1'b0;
        end
        else
        begin
          rand_addr = t.addr;
          rand_we = t.we;
          rand_req = 1'b1;
          do step(); while (!rand_grant);
          rand_req = 1'b0;
        end
      end
    endcase
    compare_entry(i);
  endtask

  initial
  begin
    RST = 1'b0;
    refresh_strobe = 1'b0;
    rand_addr = '0;
    bulk_addr = '0;
    rand_we = 1'b0;
    bulk_we = 1'b0;
    rand_req = 1'b0;
    bulk_req = 1'b0;
    void'($urandom(32'h59008c9b));
    tbl[0] = '{0, 1'b0, mk_addr(14'h0123, 1), 1'b0, '0};
    tbl[1] = '{1, 1'b1, mk_addr(14'h0123, 1), 1'b0, '0};
    tbl[2] = '{0, 1'b0, mk_addr(14'h0456, 1), 1'b0, '0};  // Row miss
    tbl[3] = '{3, 1'b0, '0, 1'b0, '0};
    tbl[4] = '{0, 1'b1, mk_addr(14'h0456, 2), 1'b0, '0};
    tbl[5] = '{2, 1'b0, mk_addr(14'h0456, 2), 1'b1, mk_addr(14'h0456, 2)};
    tbl[6] = '{0, 1'b0, mk_addr(14'h3a5c, 5), 1'b0, '0};
    repeat (3) @(negedge INPUT_CLK);
    check_value("reset cmd", NOOP, cmd);
    check_value("reset sdram_addr", 'h400, sdram_addr);
    check_value("reset grants", 0, {rand_grant, bulk_grant});
    RST = 1'b1;
    for (int i = 0; i < N_ENTRY; i++)
      apply_entry(i);
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: verif/sdram_cmd_sched_props.sv
`timescale 1ns/1ps

module sdram_cmd_sched_props import sdram_pkg::*; (
  input logic INPUT_CLK,
  input logic RST,
  input sdram_cmd_e cmd,
  input logic rand_grant,
  input logic bulk_grant
);

  // Two-stroke rule
  a_noop_after_cmd: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    (cmd != NOOP) |=> (cmd == NOOP))
    else $error("command not followed by NOOP");

  a_grant_with_rw: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    (rand_grant || bulk_grant) |-> (cmd == READ || cmd == WRTE))
    else $error("grant without READ or WRITE");

  a_one_grant: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    !(rand_grant && bulk_grant))
    else $error("both grants high");

endmodule

bind sdram_cmd_sched sdram_cmd_sched_props u_props (
  .INPUT_CLK  (INPUT_CLK),
  .RST        (RST),
  .cmd        (cmd),
  .rand_grant (rand_grant),
  .bulk_grant (bulk_grant)
);

// File: design/sdram_cmd_sched.sv
`timescale 1ns/1ps
`include "sdram_macros.svh"

module sdram_cmd_sched import sdram_pkg::*; (
  input  logic INPUT_CLK,
  input  logic RST,
  input  logic refresh_strobe,
  input  logic [`SDRAM_ADDR_W-1:0] rand_addr,
  input  logic rand_we,
  input  logic rand_req,
  input  logic [`SDRAM_ADDR_W-1:0] bulk_addr,
  input  logic bulk_we,
  input  logic bulk_req,
  output logic rand_grant,
  output logic bulk_grant,
  output sdram_cmd_e cmd,
  output logic [`SDRAM_ROW_W-1:0] sdram_addr,
  output logic [`SDRAM_BANK_W-1:0] bank
);
  logic issue;
  sdram_cmd_e issued_cmd;
  logic second_stroke;

  req_if req_bus ();
  page_if page_bus ();

  req_latch u_req_latch (
    .INPUT_CLK (INPUT_CLK),
    .RST       (RST),
    .rand_addr (rand_addr),
    .rand_we   (rand_we),
    .rand_req  (rand_req),
    .bulk_addr (bulk_addr),
    .bulk_we   (bulk_we),
    .bulk_req  (bulk_req),
    .req       (req_bus.src),
    .pg        (page_bus.seq)
  );

  page_tracker u_page_tracker (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .issue          (issue),
    .issued_cmd     (issued_cmd),
    .second_stroke  (second_stroke),
    .req            (req_bus.seq),
    .pg             (page_bus.trk)
  );

  cmd_sequencer u_cmd_sequencer (
    .INPUT_CLK     (INPUT_CLK),
    .RST           (RST),
    .req           (req_bus.seq),
    .pg            (page_bus.seq),
    .issue         (issue),
    .issued_cmd    (issued_cmd),
    .second_stroke (second_stroke),
    .rand_grant    (rand_grant),
    .bulk_grant    (bulk_grant),
    .cmd           (cmd)
  );

  addr_gen u_addr_gen (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .issue      (issue),
    .issued_cmd (issued_cmd),
    .req        (req_bus.addr),
    .pg         (page_bus.addr),
    .sdram_addr (sdram_addr),
    .bank       (bank)
  );

endmodule

// File: design/addr_gen.sv
`timescale 1ns/1ps
`include "sdram_macros.svh"

module addr_gen import sdram_pkg::*; (
  input  logic INPUT_CLK,
  input  logic RST,
  input  logic issue,
  input  sdram_cmd_e issued_cmd,
  req_if.addr req,
  page_if.addr pg,
  output logic [`SDRAM_ROW_W-1:0] sdram_addr,
  output logic [`SDRAM_BANK_W-1:0] bank
);
  sdram_page_t req_page;
  sdram_col_t req_col;
  logic load;
  logic leaving;
  logic [`SDRAM_ROW_W-1:0] addr_next;

  assign req_page = req.req_addr[`SDRAM_ADDR_W-1 -: `SDRAM_PAGE_W];
  assign req_col = req.req_addr[`SDRAM_COL_W-1:0];
  assign load = issue && (issued_cmd != NOOP);
  assign leaving = pg.page_active && !req.hit_any;

  always_comb
  begin
    if (leaving)
      addr_next = `SDRAM_PRCH_ALL_ADDR;
    else if (req.hit_any)
      addr_next = {{(`SDRAM_ROW_W-`SDRAM_COL_W-1){1'b0}}, req_col, 1'b0};  // 32-bit words
    else
      addr_next = req_page.row;
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      sdram_addr <= `SDRAM_PRCH_ALL_ADDR;
      bank <= '0;
    end
    else if (load)
    begin
      sdram_addr <= addr_next;
      if (!leaving)
        bank <= req.hit_any ? pg.cur_page.bank : req_page.bank;
    end
  end

endmodule

// File: design/cmd_sequencer.sv
`timescale 1ns/1ps
`include "sdram_macros.svh"

module cmd_sequencer import sdram_pkg::*; (
  input  logic INPUT_CLK,
  input  logic RST,
  req_if.seq req,
  page_if.seq pg,
  output logic issue,
  output sdram_cmd_e issued_cmd,
  output logic second_stroke,
  output logic rand_grant,
  output logic bulk_grant,
  output sdram_cmd_e cmd
);
  logic [`SDRAM_CNT_W-1:0] wait_cnt;
  logic change_possible_n;
  logic state_is_rw;
  logic extra_pass;
  logic write_match;
  logic norm_end;
  logic dlay_end;
  logic change_possible_w_n;
  logic on_page;
  logic override;
  sdram_cmd_e cmd_non_rw;

  assign write_match = req.bulk_req ? req.bulk_we : (req.rand_req && req.rand_we);

  // Issue decision --------------------------------
  assign on_page = second_stroke && state_is_rw && (pg.last_was_write == write_match);
  assign override = second_stroke && !change_possible_n &&
                    (req.rand_req || req.bulk_req || pg.refresh_time);
  assign issue = (req.hit_any && on_page) || override;

  always_comb
  begin
    if (pg.page_active)
      cmd_non_rw = pg.actv_timed_out ? PRCH : NOOP;  // Row still too young
    else
      cmd_non_rw = pg.refresh_time ? ARSR : ACTV;
  end

  assign issued_cmd = req.hit_any ? (write_match ? WRTE : READ) : cmd_non_rw;

  // Wait counter windows --------------------------
  assign norm_end = (wait_cnt == `SDRAM_CNT_NORM_END) ||
                    (wait_cnt == (`SDRAM_CNT_NORM_END + `SDRAM_CNT_W'(1)));
  assign dlay_end = (wait_cnt == `SDRAM_CNT_DLAY_END) ||
                    (wait_cnt == (`SDRAM_CNT_DLAY_END + `SDRAM_CNT_W'(1)));

  always_comb
  begin
    if (!second_stroke)
      change_possible_w_n = 1'b1;
    else if (req.hit_any)
      change_possible_w_n = !norm_end;
    else if (extra_pass)
      change_possible_w_n = 1'b1;  // Second lap after refresh
    else if (pg.page_active && pg.last_was_write)
      change_possible_w_n = !dlay_end;
    else
      change_possible_w_n = !norm_end;
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      cmd <= NOOP;
      second_stroke <= 1'b1;
      change_possible_n <= 1'b1;
      state_is_rw <= 1'b0;
      extra_pass <= 1'b0;
      wait_cnt <= `SDRAM_CNT_IDLE;
      rand_grant <= 1'b0;
      bulk_grant <= 1'b0;
    end
    else
    begin
      cmd <= issue ? issued_cmd : NOOP;
      second_stroke <= !issue;  // NOOP after every command
      rand_grant <= issue && req.hit_rand;
      bulk_grant <= issue && req.hit_bulk;
      if (issue)
      begin
        change_possible_n <= 1'b1;
        state_is_rw <= req.hit_any;
      end
      else
        change_possible_n <= change_possible_w_n;
      if (!second_stroke)
      begin
        case (cmd)
          ARSR: wait_cnt <= `SDRAM_CNT_ARSR;
          ACTV: wait_cnt <= `SDRAM_CNT_ACTV;
          NOOP: wait_cnt <= `SDRAM_CNT_IDLE;
          default: wait_cnt <= `SDRAM_CNT_RW;
        endcase
        if (cmd == ARSR)
          extra_pass <= 1'b1;
      end
      else
      begin
        wait_cnt <= wait_cnt + {{(`SDRAM_CNT_W-1){1'b0}}, change_possible_n};
        if (wait_cnt == '0)
          extra_pass <= 1'b0;
      end
    end
  end

endmodule

// File: design/page_tracker.sv
`timescale 1ns/1ps
`include "sdram_macros.svh"

module page_tracker import sdram_pkg::*; (
  input  logic INPUT_CLK,
  input  logic RST,
  input  logic refresh_strobe,
  input  logic issue,
  input  sdram_cmd_e issued_cmd,
  input  logic second_stroke,
  req_if.seq req,
  page_if.trk pg
);
  sdram_cmd_e stroke_cmd;  // Command on the bus during the second stroke
  logic refresh_ack;
  logic [`SDRAM_TMO_W-1:0] actv_tmo;

  assign pg.actv_timed_out = actv_tmo[`SDRAM_TMO_W-1];

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      stroke_cmd <= NOOP;
      refresh_ack <= 1'b0;
      pg.refresh_time <= 1'b0;
      pg.page_active <= 1'b0;
      pg.last_was_write <= 1'b0;
      actv_tmo <= '1;
    end
    else
    begin
      stroke_cmd <= issue ? issued_cmd : NOOP;
      pg.refresh_time <= refresh_strobe ^ refresh_ack;  // Each toggle is one refresh

      // Activate timeout ------------------------------
      if (!second_stroke && (stroke_cmd == ACTV))
        actv_tmo <= '0;
      else if (!pg.actv_timed_out)
        actv_tmo <= actv_tmo + `SDRAM_TMO_W'(1);

      // Page state, settled on the second stroke ------
      if (!second_stroke)
      begin
        case (stroke_cmd)
          ACTV: pg.page_active <= 1'b1;
          PRCH: pg.page_active <= 1'b0;
          ARSR: refresh_ack <= refresh_strobe;
          default: pg.page_active <= pg.page_active;
        endcase
        if (stroke_cmd == WRTE)
          pg.last_was_write <= 1'b1;
        else if (stroke_cmd != NOOP)
          pg.last_was_write <= 1'b0;
      end
    end
  end

  // Row and bank of the page being opened
  always_ff @(posedge INPUT_CLK)
  begin
    if (issue && (issued_cmd == ACTV))
      pg.cur_page <= req.req_addr[`SDRAM_ADDR_W-1 -: `SDRAM_PAGE_W];
  end

endmodule

// File: design/req_latch.sv
`timescale 1ns/1ps
`include "sdram_macros.svh"

module req_latch import sdram_pkg::*; (
  input  logic INPUT_CLK,
  input  logic RST,
  input  logic [`SDRAM_ADDR_W-1:0] rand_addr,
  input  logic rand_we,
  input  logic rand_req,
  input  logic [`SDRAM_ADDR_W-1:0] bulk_addr,
  input  logic bulk_we,
  input  logic bulk_req,
  req_if.src req,
  page_if.seq pg
);
  logic [`SDRAM_ADDR_W-1:0] rand_addr_q;
  logic [`SDRAM_ADDR_W-1:0] bulk_addr_q;
  sdram_page_t rand_page;
  sdram_page_t bulk_page;
  logic page_open;
  logic hit_rand_w;
  logic hit_bulk_w;

  // Hits are judged on the live port, one cycle ahead of the latch
  assign rand_page = rand_addr[`SDRAM_ADDR_W-1 -: `SDRAM_PAGE_W];
  assign bulk_page = bulk_addr[`SDRAM_ADDR_W-1 -: `SDRAM_PAGE_W];
  assign page_open = pg.page_active && !pg.refresh_time;

  assign hit_rand_w = rand_req && !bulk_req && page_open &&
                      (rand_page == pg.cur_page);  // Bulk wins
  assign hit_bulk_w = bulk_req && page_open && (bulk_page == pg.cur_page);

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      req.rand_req <= 1'b0;
      req.rand_we <= 1'b0;
      req.bulk_req <= 1'b0;
      req.bulk_we <= 1'b0;
      req.hit_rand <= 1'b0;
      req.hit_bulk <= 1'b0;
      req.hit_any <= 1'b0;
    end
    else
    begin
      req.rand_req <= rand_req;
      req.rand_we <= rand_we;
      req.bulk_req <= bulk_req;
      req.bulk_we <= bulk_we;
      req.hit_rand <= hit_rand_w;
      req.hit_bulk <= hit_bulk_w;
      req.hit_any <= hit_rand_w || hit_bulk_w;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    rand_addr_q <= rand_addr;
    bulk_addr_q <= bulk_addr;
  end

  assign req.req_addr = req.bulk_req ? bulk_addr_q : rand_addr_q;

endmodule

// File: design/page_if.sv
`timescale 1ns/1ps

interface page_if import sdram_pkg::*; ();
  logic page_active;
  logic last_was_write;
  logic refresh_time;
  logic actv_timed_out;
  sdram_page_t cur_page;

  modport trk (output page_active, last_was_write, refresh_time,
               actv_timed_out, cur_page);

  modport seq (input page_active, last_was_write, refresh_time,
               actv_timed_out, cur_page);

  modport addr (input page_active, cur_page);

endinterface

// File: design/req_if.sv
`timescale 1ns/1ps
`include "sdram_macros.svh"

interface req_if ();
  logic rand_req;
  logic rand_we;
  logic bulk_req;
  logic bulk_we;
  logic [`SDRAM_ADDR_W-1:0] req_addr;  // Bulk address when bulk requests
  logic hit_rand;
  logic hit_bulk;
  logic hit_any;

  modport src (output rand_req, rand_we, bulk_req, bulk_we, req_addr,
               hit_rand, hit_bulk, hit_any);

  modport seq (input rand_req, rand_we, bulk_req, bulk_we, req_addr,
               hit_rand, hit_bulk, hit_any);

  modport addr (input req_addr, hit_any);

endinterface

// File: design/sdram_pkg.sv
`include "sdram_macros.svh"

package sdram_pkg;

  // SDRAM command pins, CS RAS CAS WE with CS held low
  typedef enum logic [2:0] {
    MRST = 3'b000,
    ARSR = 3'b001,
    PRCH = 3'b010,
    ACTV = 3'b011,
    WRTE = 3'b100,
    READ = 3'b101,
    BTRM = 3'b110,
    NOOP = 3'b111
  } sdram_cmd_e;

  typedef logic [`SDRAM_ROW_W-1:0] sdram_row_t;
  typedef logic [`SDRAM_BANK_W-1:0] sdram_bank_t;
  typedef logic [`SDRAM_COL_W-1:0] sdram_col_t;

  typedef struct packed {
    sdram_row_t row;
    sdram_bank_t bank;
  } sdram_page_t;

endpackage

// File: design/sdram_macros.svh
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// Request address is row, bank, column from the top
`define SDRAM_ADDR_W 26
`define SDRAM_ROW_W 14
`define SDRAM_BANK_W 3
`define SDRAM_COL_W 9
`define SDRAM_PAGE_W 17

`define SDRAM_PRCH_ALL_ADDR 14'h0400  // A10 high

// Wait counter reloads and end windows
`define SDRAM_CNT_W 4
`define SDRAM_CNT_ARSR 4'h3       // After refresh
`define SDRAM_CNT_ACTV 4'hc       // After activate
`define SDRAM_CNT_RW 4'hb
`define SDRAM_CNT_IDLE 4'he
`define SDRAM_CNT_NORM_END 4'hd   // Window is END and END+1
`define SDRAM_CNT_DLAY_END 4'he   // Write recovery before precharge

`define SDRAM_TMO_W 3

`endif
